/* Bender.yml */
package:
  name: int_alu

export_include_dirs:
  - include

sources:
  - source/aluInstrPkg.sv
  - source/aluDataPkg.sv
  - source/aluDecode.sv
  - source/aluArith.sv
  - source/seqMultiplier.sv
  - source/aluResult.sv
  - source/intAlu.sv
  - target: test
    files:
      - verification/tbClockGen.sv
      - verification/intAlu_assertions.sv
      - verification/intAlu_tb.sv

/* include/alu_consts.svh */
// Integer ALU constants for widths, instruction fields, codes and register numbers
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define ALU_WIDTH   64

// ==========================================================================
// Instruction fields
// ==========================================================================
`define OPCODE_LO   0
`define OPCODE_HI   5
`define FUNCT_LO    26
`define FUNCT_HI    31
`define SIZE_LO     21
`define SIZE_HI     22
`define TRAP_BIT    23

`define OP_RR       6'h02
`define OP_ADDI     6'h04
`define OP_ANDI     6'h08

`define FN_ADD      6'h04
`define FN_SUB      6'h05
`define FN_CMP      6'h06
`define FN_CMPU     6'h07
`define FN_AND      6'h08
`define FN_OR       6'h09
`define FN_XOR      6'h0A
`define FN_MULU     6'h38
`define FN_MULSU    6'h39
`define FN_MUL      6'h3A

`define SIZE_BYTE   2'd0
`define SIZE_HALF   2'd1
`define SIZE_TETRA  2'd2
`define SIZE_WORD   2'd3

// ==========================================================================
// Exceptions
// ==========================================================================
`define FLT_NONE    9'd0
`define FLT_OFL     9'd16
`define FLT_STK     9'd51

`define STACK_REG   8'd31
`define FRAME_REG   8'd30

`define EXCEN_ADD   0       // excen bit indices
`define EXCEN_SUB   1
`define EXCEN_MUL   3

`endif

/* list.f */
+incdir+include
source/aluInstrPkg.sv
source/aluDataPkg.sv
source/aluDecode.sv
source/aluArith.sv
source/seqMultiplier.sv
source/aluResult.sv
source/intAlu.sv
verification/tbClockGen.sv
verification/intAlu_assertions.sv
verification/intAlu_tb.sv

/* source/aluArith.sv */
// Combinational sized add, subtract, logic and three-way compare
`timescale 1ns/1ps
`include "alu_consts.svh"

module aluArith (
    input  aluInstrPkg::aluOpE op,
    input  aluInstrPkg::sizeT  size,
    input  aluDataPkg::wordT   a,
    input  aluDataPkg::wordT   b,
    output aluDataPkg::wordT   arithOut,
    output logic               ovf
);
    import aluInstrPkg::*;
    import aluDataPkg::*;

    wordT sum;
    wordT diff;
    wordT aCmp;
    wordT bCmp;
    logic isSigned;
    logic lt;
    logic eq;

    // Extends the low bytes picked by sz, with sign or zero fill
    function automatic wordT sizeExt(input wordT v, input sizeT sz, input logic sgn);
        case (sz)
            `SIZE_BYTE:  sizeExt = {{(`ALU_WIDTH-8){sgn & v[7]}}, v[7:0]};
            `SIZE_HALF:  sizeExt = {{(`ALU_WIDTH-16){sgn & v[15]}}, v[15:0]};
            `SIZE_TETRA: sizeExt = {{(`ALU_WIDTH-32){sgn & v[31]}}, v[31:0]};
            default:     sizeExt = v;
        endcase
    endfunction

    // Narrow sums are the low bits of the full sum
    assign sum  = a + b;
    assign diff = a - b;

    // ======================================================================
    // Three-way compare
    // ======================================================================
    assign isSigned = (op == CMP);
    assign aCmp     = sizeExt(a, size, isSigned);
    assign bCmp     = sizeExt(b, size, isSigned);
    assign eq       = (aCmp == bCmp);

    always_comb begin
        if (isSigned)
            lt = $signed(aCmp) < $signed(bCmp);
        else
            lt = aCmp < bCmp;
    end

    // ======================================================================
    // Result select
    // ======================================================================
    always_comb begin
        case (op)
            ADD:     arithOut = sizeExt(sum, size, 1'b1);
            SUB:     arithOut = sizeExt(diff, size, 1'b1);
            AND:     arithOut = sizeExt(a & b, size, 1'b1);
            OR:      arithOut = sizeExt(a | b, size, 1'b1);
            XOR:     arithOut = sizeExt(a ^ b, size, 1'b1);
            CMP,
            CMPU: begin
                if (lt)
                    arithOut = '1;
                else if (eq)
                    arithOut = '0;
                else
                    arithOut = wordT'(1);
            end
            default: arithOut = '0;
        endcase
    end

    // Signed overflow of the full-width result
    always_comb begin
        case (op)
            ADD: ovf = (a[`ALU_WIDTH-1] == b[`ALU_WIDTH-1])
                     & (sum[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
            SUB: ovf = (a[`ALU_WIDTH-1] != b[`ALU_WIDTH-1])   // b is negated
                     & (diff[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);
            default: ovf = 1'b0;
        endcase
    end

endmodule

/* source/aluDataPkg.sv */
// Data side types of the integer ALU
`include "alu_consts.svh"

package aluDataPkg;

    typedef logic [`ALU_WIDTH-1:0] wordT;
    typedef logic [2*`ALU_WIDTH-1:0] dwordT;   // Full product

    typedef logic [8:0] excT;
    typedef logic [7:0] regNumT;
    typedef logic [31:0] boundT;   // Stack bounds compare the low 32 bits
    typedef logic [4:0] excEnT;

    // Multiplier sequencing
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } mulStateE;

endpackage

/* source/aluDecode.sv */
// Instruction decoder mapping opcode and function code onto one ALU operation
`timescale 1ns/1ps
`include "alu_consts.svh"

module aluDecode (
    input  logic               ld,
    input  aluInstrPkg::instrT instr,
    output aluInstrPkg::aluOpE op,
    output aluInstrPkg::sizeT  size,
    output logic               trapEn,
    output logic               mulStart,
    output logic               mulSgn,
    output logic               mulSgnus
);
    import aluInstrPkg::*;

    opcodeT opcode;
    functT  funct;
    logic   isRR;

    assign opcode = instr[`OPCODE_HI:`OPCODE_LO];
    assign funct  = instr[`FUNCT_HI:`FUNCT_LO];
    assign isRR   = (opcode == `OP_RR);

    always_comb begin
        op       = NONE;
        mulSgn   = 1'b0;
        mulSgnus = 1'b0;
        case (opcode)
            `OP_RR: begin
                case (funct)
                    `FN_ADD:  op = ADD;
                    `FN_SUB:  op = SUB;
                    `FN_AND:  op = AND;
                    `FN_OR:   op = OR;
                    `FN_XOR:  op = XOR;
                    `FN_CMP:  op = CMP;
                    `FN_CMPU: op = CMPU;
                    `FN_MULU: op = MUL;
                    `FN_MULSU: begin
                        op       = MUL;
                        mulSgnus = 1'b1;   // Only a is signed
                    end
                    `FN_MUL: begin
                        op     = MUL;
                        mulSgn = 1'b1;
                    end
                    default: op = NONE;
                endcase
            end
            `OP_ADDI: op = ADD;
            `OP_ANDI: op = AND;
            default:  op = NONE;
        endcase
    end

    // Immediates always work on the full word
    assign size     = isRR ? instr[`SIZE_HI:`SIZE_LO] : `SIZE_WORD;
    assign trapEn   = isRR & instr[`TRAP_BIT];
    assign mulStart = ld & (op == MUL);

endmodule

/* source/aluInstrPkg.sv */
// Instruction side types of the integer ALU
`include "alu_consts.svh"

package aluInstrPkg;

    // Raw instruction word and its fields
    typedef logic [31:0] instrT;
    typedef logic [`OPCODE_HI-`OPCODE_LO:0] opcodeT;
    typedef logic [`FUNCT_HI-`FUNCT_LO:0] functT;

    // 0 is byte, 3 is the full word
    typedef logic [`SIZE_HI-`SIZE_LO:0] sizeT;

    // ======================================================================
    // Decoded operation
    // ======================================================================
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        CMP,
        CMPU,
        MUL,    // Covers MUL, MULU and MULSU
        NONE
    } aluOpE;

endpackage

/* source/aluResult.sv */
// Result stage selecting o and ob, completion status and exception code
`timescale 1ns/1ps
`include "alu_consts.svh"

module aluResult (
    input  aluInstrPkg::aluOpE op,
    input  logic               trapEn,
    input  aluDataPkg::wordT   arithOut,
    input  logic               ovf,
    input  aluDataPkg::dwordT  prod,
    input  logic               mulDone,
    input  logic               mulIdle,
    input  aluDataPkg::regNumT tgt,
    input  aluDataPkg::boundT  sbl,
    input  aluDataPkg::boundT  sbu,
    input  aluDataPkg::excEnT  excen,
    output aluDataPkg::wordT   o,
    output aluDataPkg::wordT   ob,
    output logic               done,
    output logic               idle,
    output aluDataPkg::excT    exc
);
    import aluInstrPkg::*;
    import aluDataPkg::*;

    wordT prodHi;
    logic isMul;
    logic stkFault;
    logic ovfFault;

    assign isMul  = (op == MUL);
    assign prodHi = prod[2*`ALU_WIDTH-1:`ALU_WIDTH];

    assign o    = isMul ? prod[`ALU_WIDTH-1:0] : arithOut;
    assign ob   = isMul ? prodHi : '0;
    assign done = isMul ? mulDone : 1'b1;   // Everything else is single cycle
    assign idle = isMul ? mulIdle : 1'b1;

    // ======================================================================
    // Exceptions
    // ======================================================================
    assign stkFault = ((tgt == `STACK_REG) || (tgt == `FRAME_REG))
                    && ((o[31:0] < sbl) || (o[31:0] > sbu));

    always_comb begin
        case (op)
            ADD:     ovfFault = ovf & trapEn & excen[`EXCEN_ADD];
            SUB:     ovfFault = ovf & trapEn & excen[`EXCEN_SUB];
            MUL:     ovfFault = excen[`EXCEN_MUL]
                              & (prodHi != {`ALU_WIDTH{o[`ALU_WIDTH-1]}});
            default: ovfFault = 1'b0;
        endcase
    end

    // Stack fault wins over overflow
    always_comb begin
        if (stkFault)
            exc = `FLT_STK;
        else if (ovfFault)
            exc = `FLT_OFL;
        else
            exc = `FLT_NONE;
    end

endmodule

/* source/intAlu.sv */
// Top of the 64-bit integer ALU for the execute stage
`timescale 1ns/1ps
`include "alu_consts.svh"

module intAlu (
    input  logic               clk,
    input  logic               arstN,
    input  logic               ld,
    input  logic               abort,
    input  aluInstrPkg::instrT instr,
    input  aluDataPkg::wordT   a,
    input  aluDataPkg::wordT   b,
    input  aluDataPkg::regNumT tgt,
    input  aluDataPkg::boundT  sbl,
    input  aluDataPkg::boundT  sbu,
    input  aluDataPkg::excEnT  excen,
    output aluDataPkg::wordT   o,
    output aluDataPkg::wordT   ob,
    output logic               done,
    output logic               idle,
    output aluDataPkg::excT    exc
);
    import aluInstrPkg::*;
    import aluDataPkg::*;

    aluOpE op;
    sizeT  size;
    logic  trapEn;
    logic  mulStart;
    logic  mulSgn;
    logic  mulSgnus;
    wordT  arithOut;
    logic  ovf;
    dwordT prod;
    logic  mulDone;
    logic  mulIdle;

    aluDecode u_decode (
        .ld       (ld),
        .instr    (instr),
        .op       (op),
        .size     (size),
        .trapEn   (trapEn),
        .mulStart (mulStart),
        .mulSgn   (mulSgn),
        .mulSgnus (mulSgnus)
    );

    aluArith u_arith (
        .op       (op),
        .size     (size),
        .a        (a),
        .b        (b),
        .arithOut (arithOut),
        .ovf      (ovf)
    );

    seqMultiplier #(.width(`ALU_WIDTH)) u_mult (
        .clk   (clk),
        .arstN (arstN),
        .ld    (mulStart),
        .abort (abort),
        .sgn   (mulSgn),
        .sgnus (mulSgnus),
        .a     (a),
        .b     (b),
        .prod  (prod),
        .done  (mulDone),
        .idle  (mulIdle)
    );

    aluResult u_result (
        .op       (op),
        .trapEn   (trapEn),
        .arithOut (arithOut),
        .ovf      (ovf),
        .prod     (prod),
        .mulDone  (mulDone),
        .mulIdle  (mulIdle),
        .tgt      (tgt),
        .sbl      (sbl),
        .sbu      (sbu),
        .excen    (excen),
        .o        (o),
        .ob       (ob),
        .done     (done),
        .idle     (idle),
        .exc      (exc)
    );

endmodule

/* source/seqMultiplier.sv */
// Iterative shift-add multiplier with sign correction and abort
`timescale 1ns/1ps
`include "alu_consts.svh"

module seqMultiplier #(
    parameter int width = `ALU_WIDTH
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 ld,
    input  logic                 abort,
    input  logic                 sgn,
    input  logic                 sgnus,
    input  logic [width-1:0]     a,
    input  logic [width-1:0]     b,
    output logic [2*width-1:0]   prod,
    output logic                 done,
    output logic                 idle
);
    import aluDataPkg::*;

    localparam int CntW = $clog2(width);

    mulStateE           state;
    logic [CntW-1:0]    cnt;
    logic [width-1:0]   aMag;
    logic [2*width-1:0] acc;       // Partial product over multiplier bits
    logic               negate;
    logic               aNeg;
    logic               bNeg;
    logic [width:0]     partial;

    assign aNeg = (sgn | sgnus) & a[width-1];
    assign bNeg = sgn & b[width-1];

    // One add step, carry kept in the top bit
    assign partial = {1'b0, acc[2*width-1:width]} + (acc[0] ? {1'b0, aMag} : '0);

    // ======================================================================
    // Control
    // ======================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
            cnt   <= '0;
            prod  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (ld) begin
                        state <= RUN;
                        cnt   <= '0;
                    end
                end
                RUN: begin
                    if (abort)
                        state <= IDLE;
                    else begin
                        cnt <= cnt + 1'b1;
                        if (cnt == CntW'(width-1))
                            state <= FIX;
                    end
                end
                FIX: begin
                    state <= IDLE;
                    if (!abort)
                        prod <= negate ? -acc : acc;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Operand magnitudes and partial product
    always_ff @(posedge clk) begin
        if (state == IDLE && ld) begin
            aMag   <= aNeg ? -a : a;
            acc    <= {{width{1'b0}}, (bNeg ? -b : b)};
            negate <= aNeg ^ bNeg;
        end else if (state == RUN) begin
            acc <= {partial, acc[width-1:1]};
        end
    end

    assign done = (state == IDLE);
    assign idle = (state == IDLE);

endmodule

/* verification/intAlu_assertions.sv */
// Concurrent checks on the multiplier handshake, bound into the multiplier
`timescale 1ns/1ps

module intAluAssertions (
    input logic clk,
    input logic arstN,
    input logic ld,
    input logic abort,
    input logic done,
    input logic idle
);

    int failCount;   // Read by the testbench at the end of the run

    // No new operation while busy
    assert property (@(posedge clk) disable iff (!arstN) !idle |-> !ld)
        else begin
            $error("ld asserted while the multiplier is busy");
            failCount++;
        end

    // 64 RUN cycles, one FIX cycle, then done
    assert property (@(posedge clk) disable iff (!arstN || abort)
        (ld && idle) |=> !done [*65] ##1 done)
        else begin
            $error("done did not rise 65 cycles after an accepted ld");
            failCount++;
        end

    assert property (@(posedge clk) $rose(arstN) |-> (done && idle))
        else begin
            $error("done or idle low in the cycle after reset release");
            failCount++;
        end

endmodule

bind seqMultiplier intAluAssertions asrt0 (
    .clk   (clk),
    .arstN (arstN),
    .ld    (ld),
    .abort (abort),
    .done  (done),
    .idle  (idle)
);

/* verification/intAlu_tb.sv */
// Table-driven testbench for the integer ALU with its own result model
`timescale 1ns/1ps
`include "alu_consts.svh"

module intAlu_tb;
    import aluInstrPkg::*;
    import aluDataPkg::*;

    typedef struct {
        string  name;
        instrT  instr;
        wordT   a;
        wordT   b;
        regNumT tgt;
        boundT  sbl;
        boundT  sbu;
        excEnT  excen;
        wordT   expO;
        wordT   expOb;
        excT    expExc;
        logic   doAbort;
    } rowT;

    logic   clk;
    logic   arstN;
    logic   ld;
    logic   abort;
    instrT  instr;
    wordT   a;
    wordT   b;
    regNumT tgt;
    boundT  sbl;
    boundT  sbu;
    excEnT  excen;
    wordT   o;
    wordT   ob;
    logic   done;
    logic   idle;
    excT    exc;

    rowT rows[$];
    int  errors;
    int  cycles;
    int  cycleLimit;

    tbClockGen #(.periodNs(40), .resetCycles(3)) clkGen0 (.clk(clk), .arstN(arstN));

    intAlu dut0 (
        .clk(clk), .arstN(arstN), .ld(ld), .abort(abort), .instr(instr), .a(a), .b(b),
        .tgt(tgt), .sbl(sbl), .sbu(sbu), .excen(excen),
        .o(o), .ob(ob), .done(done), .idle(idle), .exc(exc)
    );

    function automatic instrT rrInstr(input functT f, input sizeT sz, input logic trap);
        return {f, 2'b00, trap, sz, 15'b0, `OP_RR};
    endfunction

    function automatic instrT immInstr(input opcodeT opc);
        return {26'b0, opc};
    endfunction

    // Keep the low 8 << sz bits, fill upward with their top bit
    function automatic wordT signExt(input wordT v, input sizeT sz);
        int sh;
        sh = 64 - (8 << sz);
        return wordT'($signed(v << sh) >>> sh);
    endfunction

    function automatic logic isMulInstr(input instrT ins);
        functT f;
        f = ins[`FUNCT_HI:`FUNCT_LO];
        return (ins[`OPCODE_HI:`OPCODE_LO] == `OP_RR)
            && (f == `FN_MUL || f == `FN_MULU || f == `FN_MULSU);
    endfunction

    task automatic checkValue(input string name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic runRow(input rowT r);
        int n;
        @(posedge clk);
        #1;
        instr = r.instr;
        a     = r.a;
        b     = r.b;
        tgt   = r.tgt;
        sbl   = r.sbl;
        sbu   = r.sbu;
        excen = r.excen;
        ld    = 1'b1;
        @(posedge clk);
        #1;
        ld = 1'b0;
        n  = 0;
        if (r.doAbort) begin
            repeat (9) @(posedge clk);
            #1;
            if (done) begin
                errors++;
                $display("%s: multiplier not busy when abort was applied", r.name);
            end
            abort = 1'b1;
            @(posedge clk);
            #1;
            abort = 1'b0;
            while (!done && n < 2) begin
                @(posedge clk);
                #1;
                n++;
            end
            if (!done || !idle) begin
                errors++;
                $display("%s: done and idle not back within two cycles of abort", r.name);
            end
        end else begin
            while (!done) begin
                @(posedge clk);
                #1;
                n++;
            end
            if (isMulInstr(r.instr))
                checkValue(r.name, "cycles", 65, n);
            checkValue(r.name, "idle", 1, idle);
            checkValue(r.name, "o", r.expO, o);
            checkValue(r.name, "ob", r.expOb, ob);
            checkValue(r.name, "exc", r.expExc, exc);
        end
    endtask

    // ========================================================================
    // Timeout
    // ========================================================================
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        rowT   r;
        int    kind;
        sizeT  sz;
        dwordT p;
        void'($urandom(70677));
        ld    = 1'b0;
        abort = 1'b0;
        instr = '0;
        a     = '0;
        b     = '0;
        tgt   = '0;
        sbl   = '0;
        sbu   = '0;
        excen = '0;

        // name, instr, a, b, tgt, sbl, sbu, excen, o, ob, exc, abort
        rows.push_back('{"addb", rrInstr(`FN_ADD, 0, 0), 'h7F, 1, 5, 0, '1, 0, -128, 0, 0, 0});
        rows.push_back('{"subh", rrInstr(`FN_SUB, 1, 0), 'h8000, 1, 5, 0, '1, 0, 'h7FFF, 0, 0, 0});
        rows.push_back('{"andt", rrInstr(`FN_AND, 2, 0), 64'h123456789ABCDEF0,
                         64'hFFFFFFFFFFFF0000, 5, 0, '1, 0, 64'hFFFFFFFF9ABC0000, 0, 0, 0});
        rows.push_back('{"ort", rrInstr(`FN_OR, 2, 0), 64'hAAAA000012340000,
                         64'h5555000000005678, 5, 0, '1, 0, 'h12345678, 0, 0, 0});
        rows.push_back('{"xort", rrInstr(`FN_XOR, 2, 0), 'hF0F0F0F0, 'h0F0F0F0F, 5, 0, '1, 0,
                         -1, 0, 0, 0});
        rows.push_back('{"addi", immInstr(`OP_ADDI), -1, 2, 5, 0, '1, 0, 1, 0, 0, 0});
        rows.push_back('{"andi", immInstr(`OP_ANDI), 64'hFF00FF00FF00FF00,
                         64'h0F0F0F0F0F0F0F0F, 5, 0, '1, 0, 64'h0F000F000F000F00, 0, 0, 0});
        rows.push_back('{"cmplt", rrInstr(`FN_CMP, 3, 0), -1, 1, 5, 0, '1, 0, -1, 0, 0, 0});
        rows.push_back('{"cmpugt", rrInstr(`FN_CMPU, 3, 0), -1, 1, 5, 0, '1, 0, 1, 0, 0, 0});
        rows.push_back('{"cmpeq", rrInstr(`FN_CMP, 0, 0), 'hAB, -85, 5, 0, '1, 0, 0, 0, 0, 0});
        rows.push_back('{"mul", rrInstr(`FN_MUL, 3, 0), -3, 7, 5, 0, '1, 'h08, -21, -1, 0, 0});
        rows.push_back('{"mulu", rrInstr(`FN_MULU, 3, 0), -1, -1, 5, 0, '1, 0, 1, -2, 0, 0});
        rows.push_back('{"mulsu", rrInstr(`FN_MULSU, 3, 0), -2, -1, 5, 0, '1, 0, 2, -2, 0, 0});
        rows.push_back('{"mulofl", rrInstr(`FN_MUL, 3, 0), 64'h100000000, 64'h100000000,
                         5, 0, '1, 'h08, 0, 1, `FLT_OFL, 0});
        rows.push_back('{"addofl", rrInstr(`FN_ADD, 3, 1), 64'h7FFFFFFFFFFFFFFF, 1, 5, 0, '1, 1,
                         64'h8000000000000000, 0, `FLT_OFL, 0});
        rows.push_back('{"addnotrap", rrInstr(`FN_ADD, 3, 0), 64'h7FFFFFFFFFFFFFFF, 1, 5, 0, '1,
                         1, 64'h8000000000000000, 0, `FLT_NONE, 0});
        rows.push_back('{"addnoen", rrInstr(`FN_ADD, 3, 1), 64'h7FFFFFFFFFFFFFFF, 1, 5, 0, '1,
                         0, 64'h8000000000000000, 0, `FLT_NONE, 0});
        rows.push_back('{"stk", rrInstr(`FN_ADD, 3, 1), 64'h7FFFFFFFFFFFFFFF, 1, 31, 'h1000,
                         'h2000, 1, 64'h8000000000000000, 0, `FLT_STK, 0});
        rows.push_back('{"stkother", rrInstr(`FN_ADD, 3, 1), 64'h7FFFFFFFFFFFFFFF, 1, 5, 'h1000,
                         'h2000, 1, 64'h8000000000000000, 0, `FLT_OFL, 0});
        rows.push_back('{"abort", rrInstr(`FN_MUL, 3, 0), 5, 6, 5, 0, '1, 0, 0, 0, 0, 1});
        rows.push_back('{"mulafter", rrInstr(`FN_MULU, 3, 0), 64'h123456789, 'h10, 5, 0, '1, 0,
                         64'h1234567890, 0, 0, 0});

        // Random sized ADD, XOR and full-width MULU
        for (int i = 0; i < 20; i++) begin
            kind = $urandom % 3;
            sz   = sizeT'($urandom % 4);
            r = '{$sformatf("rand%0d", i), 0, {$urandom, $urandom}, {$urandom, $urandom},
                  5, 0, '1, 0, 0, 0, `FLT_NONE, 0};
            case (kind)
                0: begin
                    r.instr = rrInstr(`FN_ADD, sz, 0);
                    r.expO  = signExt(r.a + r.b, sz);
                end
                1: begin
                    r.instr = rrInstr(`FN_XOR, sz, 0);
                    r.expO  = signExt(r.a ^ r.b, sz);
                end
                default: begin
                    r.instr = rrInstr(`FN_MULU, 3, 0);
                    p       = {64'b0, r.a} * {64'b0, r.b};
                    r.expO  = p[63:0];
                    r.expOb = p[127:64];
                end
            endcase
            rows.push_back(r);
        end
        cycleLimit = rows.size() * 70 + 100;

        wait (arstN === 1'b1);
        foreach (rows[i])
            runRow(rows[i]);

        $display("Checks done over %0d rows, errors: %0d, assertion failures: %0d",
                 rows.size(), errors, dut0.u_mult.asrt0.failCount);
        if (errors == 0 && dut0.u_mult.asrt0.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* verification/tbClockGen.sv */
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tbClockGen #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Released just after an edge, like the other inputs
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1 arstN = 1'b1;
    end

endmodule
